// File: rtl/dcache_pkg.sv
// Data cache sizes and address field positions
// Cache line and tag entry types
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W           = 32;
    localparam int DATA_W           = 32;
    localparam int LINE_W           = 128;
    localparam int WORDS_PER_LINE   = LINE_W / DATA_W;
    localparam int BYTES_PER_LINE   = LINE_W / 8;
    localparam int OFFSET_BITS      = $clog2(BYTES_PER_LINE);
    localparam int IDX_BITS         = 6;
    localparam int NUM_SETS         = 1 << IDX_BITS;
    localparam int TAG_LSB          = OFFSET_BITS + IDX_BITS;
    localparam int TAG_BITS         = ADDR_W - TAG_LSB;
    localparam int VICTIM_ENTRIES   = 4;
    localparam int VICTIM_ADDR_BITS = TAG_BITS + IDX_BITS;  // Line address

    typedef logic [LINE_W-1:0] line_t;

    // One entry of the tag RAM
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// File: rtl/dcache_ctrl_if.sv
// Strobes from the cache controller to the datapath
// and the status flags returned by the datapath
`default_nettype none

interface dcache_ctrl_if;

    logic                             cache_wr;        // Merge store into line
    logic                             line_wr;         // Refill from memory
    logic                             line_clean;      // Clear dirty bit
    logic                             victim_wr;       // Copy line to victim buffer
    logic                             victim_restore;  // Victim line back to cache
    logic                             tag_init;        // Write an invalid tag
    logic                             use_flush_idx;
    logic [dcache_pkg::IDX_BITS-1:0]  flush_idx;

    // Flags for the set read at the previous edge
    logic                             hit;
    logic                             dirty;
    logic                             valid;
    logic                             victim_hit;

    modport ctrl (
        output cache_wr, line_wr, line_clean, victim_wr, victim_restore, tag_init,
        output use_flush_idx, flush_idx,
        input  hit, dirty, valid, victim_hit
    );

    modport dp (
        input  cache_wr, line_wr, line_clean, victim_wr, victim_restore, tag_init,
        input  use_flush_idx, flush_idx,
        output hit, dirty, valid, victim_hit
    );

endinterface

`default_nettype wire

// File: rtl/dcache_sram.sv
// Single-port synchronous RAM with one entry per cache set
// Payload type is a parameter, each write enable bit covers one slice
`default_nettype none

module dcache_sram #(
    parameter type payload_t = logic [31:0],
    parameter int  SLICES    = 1
) (
    input  wire                              clk,
    input  wire                              en_i,
    input  wire  [SLICES-1:0]                we_i,
    input  wire  [dcache_pkg::IDX_BITS-1:0]  addr_i,
    input  wire  payload_t                   wdata_i,
    output payload_t                         rdata_o
);

    localparam int SLICE_W = $bits(payload_t) / SLICES;

    payload_t mem_q [dcache_pkg::NUM_SETS];

    // Read returns the old contents when the same entry is written
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem_q[addr_i];
            for (int s = 0; s < SLICES; s++) begin
                if (we_i[s]) begin
                    mem_q[addr_i][s*SLICE_W +: SLICE_W] <= wdata_i[s*SLICE_W +: SLICE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_victim.sv
// Fully associative victim buffer for clean evicted lines
// FIFO replacement, combinational lookup, take on restore, clear on flush
`default_nettype none

module dcache_victim (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      clear_i,
    input  wire                                      wr_i,
    input  wire  [dcache_pkg::VICTIM_ADDR_BITS-1:0]  wr_addr_i,
    input  wire  dcache_pkg::line_t                  wr_line_i,
    input  wire  [dcache_pkg::VICTIM_ADDR_BITS-1:0]  lookup_addr_i,
    output logic                                     hit_o,
    output dcache_pkg::line_t                        line_o,
    input  wire                                      take_i
);

    logic [dcache_pkg::VICTIM_ENTRIES-1:0]          vld_q;
    logic [dcache_pkg::VICTIM_ENTRIES-1:0]          match;
    logic [dcache_pkg::VICTIM_ADDR_BITS-1:0]        addr_q [dcache_pkg::VICTIM_ENTRIES];
    dcache_pkg::line_t                              line_q [dcache_pkg::VICTIM_ENTRIES];
    logic [$clog2(dcache_pkg::VICTIM_ENTRIES)-1:0]  wr_ptr_q;  // Oldest entry

    // At most one entry matches since a line is never stored twice
    always_comb begin
        line_o = '0;
        for (int i = 0; i < dcache_pkg::VICTIM_ENTRIES; i++) begin
            match[i] = vld_q[i] && (addr_q[i] == lookup_addr_i);
            if (match[i]) begin
                line_o = line_q[i];
            end
        end
    end

    assign hit_o = |match;

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            vld_q    <= '0;
            wr_ptr_q <= '0;
        end else begin
            if (take_i) begin
                vld_q <= vld_q & ~match;  // Line now lives in the cache again
            end
            if (wr_i) begin
                vld_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q        <= wr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            addr_q[wr_ptr_q] <= wr_addr_i;
            line_q[wr_ptr_q] <= wr_line_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_datapath.sv
// Data cache datapath with tag and data RAMs and the victim buffer
// Address split, hit compare, word select, byte merge, tag update
// and memory address and data
`default_nettype none

module dcache_datapath (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire  [dcache_pkg::ADDR_W-1:0]          addr_i,
    input  wire  [dcache_pkg::DATA_W-1:0]          wdata_i,
    input  wire  [dcache_pkg::DATA_W/8-1:0]        sel_byte_i,
    dcache_ctrl_if.dp                              ctrl,
    output logic [dcache_pkg::DATA_W-1:0]          rdata_o,
    output logic [dcache_pkg::ADDR_W-1:0]          mem_addr_o,
    output dcache_pkg::line_t                      mem_wdata_o,
    input  wire  dcache_pkg::line_t                mem_rdata_i
);

    logic [dcache_pkg::TAG_BITS-1:0]                req_tag, tag_q;
    logic [dcache_pkg::IDX_BITS-1:0]                req_idx, ram_idx;
    logic [$clog2(dcache_pkg::WORDS_PER_LINE)-1:0]  req_off, off_q;
    dcache_pkg::tag_entry_t                         tag_rd, tag_wdata;
    logic [0:0]                                     tag_we;
    dcache_pkg::line_t                              line_rd, line_wdata;
    dcache_pkg::line_t                              store_line, victim_line;
    logic [dcache_pkg::BYTES_PER_LINE-1:0]          line_we, store_be;

    assign req_tag = addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::TAG_LSB];
    assign req_idx = addr_i[dcache_pkg::TAG_LSB-1:dcache_pkg::OFFSET_BITS];
    assign req_off = addr_i[dcache_pkg::OFFSET_BITS-1 -: $clog2(dcache_pkg::WORDS_PER_LINE)];

    assign ram_idx = ctrl.use_flush_idx ? ctrl.flush_idx : req_idx;

    // Tag and offset of the request, lined up with the RAM output
    always_ff @(posedge clk) begin
        tag_q <= req_tag;
        off_q <= req_off;
    end

    assign ctrl.hit   = tag_rd.valid && (tag_rd.tag == tag_q);
    assign ctrl.valid = tag_rd.valid;
    assign ctrl.dirty = tag_rd.dirty;

    assign rdata_o = line_rd[off_q*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];

    // Store word copied to every slot, byte enables pick the slot
    assign store_line = {dcache_pkg::WORDS_PER_LINE{wdata_i}};
    assign store_be   = {{(dcache_pkg::BYTES_PER_LINE - dcache_pkg::DATA_W/8){1'b0}}, sel_byte_i}
                        << (off_q * (dcache_pkg::DATA_W / 8));

    always_comb begin
        tag_wdata  = '0;
        tag_we     = 1'b0;
        line_wdata = store_line;
        line_we    = '0;
        if (ctrl.tag_init) begin
            tag_we = 1'b1;  // All zero, so invalid
        end else if (ctrl.line_clean) begin
            tag_wdata       = tag_rd;
            tag_wdata.dirty = 1'b0;
            tag_we          = 1'b1;
        end else if (ctrl.line_wr || ctrl.victim_restore) begin
            tag_wdata  = '{valid: 1'b1, dirty: 1'b0, tag: tag_q};
            tag_we     = 1'b1;
            line_wdata = ctrl.line_wr ? mem_rdata_i : victim_line;
            line_we    = '1;
        end else if (ctrl.cache_wr) begin
            tag_wdata = '{valid: 1'b1, dirty: 1'b1, tag: tag_q};
            tag_we    = 1'b1;
            line_we   = store_be;
        end
    end

    // A dirty indexed line is written back, otherwise the request line is fetched
    assign mem_addr_o  = (tag_rd.valid && tag_rd.dirty)
                         ? {tag_rd.tag, ram_idx, {dcache_pkg::OFFSET_BITS{1'b0}}}
                         : {addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_BITS],
                            {dcache_pkg::OFFSET_BITS{1'b0}}};
    assign mem_wdata_o = line_rd;

    dcache_sram #(
        .payload_t (dcache_pkg::tag_entry_t),
        .SLICES    (1)
    ) i_tag_ram (
        .clk     (clk),
        .en_i    (1'b1),
        .we_i    (tag_we),
        .addr_i  (ram_idx),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rd)
    );

    dcache_sram #(
        .payload_t (dcache_pkg::line_t),
        .SLICES    (dcache_pkg::BYTES_PER_LINE)
    ) i_data_ram (
        .clk     (clk),
        .en_i    (1'b1),
        .we_i    (line_we),
        .addr_i  (ram_idx),
        .wdata_i (line_wdata),
        .rdata_o (line_rd)
    );

    dcache_victim i_victim (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear_i       (ctrl.use_flush_idx),
        .wr_i          (ctrl.victim_wr),
        .wr_addr_i     ({tag_rd.tag, ram_idx}),
        .wr_line_i     (line_rd),
        .lookup_addr_i (addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_BITS]),
        .hit_o         (ctrl.victim_hit),
        .line_o        (victim_line),
        .take_i        (ctrl.victim_restore)
    );

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
// Data cache controller FSM
// Hit, writeback, eviction, refill, victim restore, flush and tag init walk
`default_nettype none

module dcache_ctrl (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_i,
    input  wire           we_i,
    input  wire           flush_i,
    output logic          ack_o,
    output logic          flush_done_o,
    output logic          mem_req_o,
    output logic          mem_we_o,
    input  wire           mem_ack_i,
    dcache_ctrl_if.ctrl   ctrl
);

    typedef enum logic [3:0] {
        S_INIT,
        S_IDLE,
        S_COMPARE,
        S_WRITEBACK,
        S_EVICT,
        S_REFILL,
        S_RESTORE,
        S_FLUSH_WALK,
        S_FLUSH_WB
    } state_e;

    state_e                           state_q, state_d;
    logic [dcache_pkg::IDX_BITS-1:0]  cnt_q, cnt_d;  // Set counter for both walks
    logic                             chk_q, chk_d;  // Flush walk tag is readable
    logic                             ack_d, done_d;
    logic                             last_set;

    assign last_set = (int'(cnt_q) == dcache_pkg::NUM_SETS - 1);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        chk_d   = 1'b0;
        ack_d   = 1'b0;
        done_d  = 1'b0;
        case (state_q)
            S_INIT: begin
                cnt_d = cnt_q + 1'b1;
                if (last_set) begin
                    state_d = S_IDLE;
                end
            end
            S_IDLE: begin
                // Skip the cycle in which the previous ack or done is still up
                if (req_i && !ack_o) begin
                    state_d = S_COMPARE;
                end else if (flush_i && !flush_done_o) begin
                    state_d = S_FLUSH_WALK;
                    cnt_d   = '0;
                end
            end
            S_COMPARE: begin
                if (ctrl.hit) begin
                    state_d = S_IDLE;
                    ack_d   = 1'b1;
                end else if (ctrl.valid && ctrl.dirty) begin
                    state_d = S_WRITEBACK;
                end else if (ctrl.valid) begin
                    state_d = S_EVICT;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_WRITEBACK: if (mem_ack_i) state_d = S_EVICT;
            S_EVICT:     state_d = S_REFILL;
            S_REFILL: begin
                if (ctrl.victim_hit) begin
                    state_d = S_RESTORE;
                end else if (mem_ack_i) begin
                    state_d = S_IDLE;  // Replay the lookup
                end
            end
            S_RESTORE:   state_d = S_IDLE;
            S_FLUSH_WALK: begin
                chk_d = !chk_q;
                if (chk_q) begin
                    if (ctrl.valid && ctrl.dirty) begin
                        state_d = S_FLUSH_WB;
                    end else if (last_set) begin
                        state_d = S_IDLE;
                        done_d  = 1'b1;
                    end else begin
                        cnt_d = cnt_q + 1'b1;
                    end
                end
            end
            S_FLUSH_WB: begin
                if (mem_ack_i && last_set) begin
                    state_d = S_IDLE;
                    done_d  = 1'b1;
                end else if (mem_ack_i) begin
                    state_d = S_FLUSH_WALK;
                    cnt_d   = cnt_q + 1'b1;
                end
            end
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= S_INIT;
            cnt_q        <= '0;
            chk_q        <= 1'b0;
            ack_o        <= 1'b0;
            flush_done_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            cnt_q        <= cnt_d;
            chk_q        <= chk_d;
            ack_o        <= ack_d;
            flush_done_o <= done_d;
        end
    end

    // No memory read when the victim buffer holds the line
    assign mem_req_o = (state_q == S_WRITEBACK) || (state_q == S_FLUSH_WB) ||
                       ((state_q == S_REFILL) && !ctrl.victim_hit);
    assign mem_we_o  = (state_q == S_WRITEBACK) || (state_q == S_FLUSH_WB);

    assign ctrl.cache_wr       = (state_q == S_COMPARE) && ctrl.hit && we_i;
    assign ctrl.line_wr        = (state_q == S_REFILL) && !ctrl.victim_hit && mem_ack_i;
    assign ctrl.line_clean     = mem_we_o && mem_ack_i;  // Written back, now clean
    assign ctrl.victim_wr      = (state_q == S_EVICT);
    assign ctrl.victim_restore = (state_q == S_RESTORE);
    assign ctrl.tag_init       = (state_q == S_INIT);
    assign ctrl.use_flush_idx  = (state_q == S_INIT) || (state_q == S_FLUSH_WALK) ||
                                 (state_q == S_FLUSH_WB);
    assign ctrl.flush_idx      = cnt_q;

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
// Data cache top level
// Controller and datapath joined by the control interface
`default_nettype none

module dcache_top (
    input  wire                                clk,
    input  wire                                rst_n,

    // Requester side
    input  wire                                req_i,
    input  wire                                we_i,
    input  wire  [dcache_pkg::ADDR_W-1:0]      addr_i,
    input  wire  [dcache_pkg::DATA_W-1:0]      wdata_i,
    input  wire  [dcache_pkg::DATA_W/8-1:0]    sel_byte_i,
    input  wire                                flush_i,
    output logic [dcache_pkg::DATA_W-1:0]      rdata_o,
    output logic                               ack_o,
    output logic                               flush_done_o,

    // Line-wide memory side
    output logic                               mem_req_o,
    output logic                               mem_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]      mem_addr_o,
    output dcache_pkg::line_t                  mem_wdata_o,
    input  wire  dcache_pkg::line_t            mem_rdata_i,
    input  wire                                mem_ack_i
);

    dcache_ctrl_if i_ctrl_if ();

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .we_i         (we_i),
        .flush_i      (flush_i),
        .ack_o        (ack_o),
        .flush_done_o (flush_done_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_ack_i    (mem_ack_i),
        .ctrl         (i_ctrl_if.ctrl)
    );

    dcache_datapath i_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .sel_byte_i  (sel_byte_i),
        .ctrl        (i_ctrl_if.dp),
        .rdata_o     (rdata_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

`default_nettype wire

// File: verification/dcache_props.sv
// Concurrent assertions on the requester handshake and the memory strobes
// Bound to the cache top level
`default_nettype none

module dcache_props (
    input wire                            clk,
    input wire                            rst_n,
    input wire                            ack_o,
    input wire                            flush_done_o,
    input wire                            mem_req_o,
    input wire                            mem_we_o,
    input wire                            mem_ack_i,
    input wire [dcache_pkg::ADDR_W-1:0]   mem_addr_o
);

    int unsigned fail_count = 0;  // Number of failed assertions

    // Ack and flush done are single-cycle pulses
    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack_o |=> !ack_o)
        else begin
            $error("ack_o high on two consecutive cycles");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                 flush_done_o |=> !flush_done_o)
        else begin
            $error("flush_done_o high on two consecutive cycles");
            fail_count++;
        end

    // Memory request held with a stable address until the ack
    mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
                               mem_req_o && !mem_ack_i |=>
                               mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o))
        else begin
            $error("memory request dropped or changed before mem_ack_i");
            fail_count++;
        end

    no_ack_in_miss: assert property (@(posedge clk) disable iff (!rst_n) mem_req_o |-> !ack_o)
        else begin
            $error("ack_o high while a memory request is pending");
            fail_count++;
        end

endmodule

bind dcache_top dcache_props i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .ack_o        (ack_o),
    .flush_done_o (flush_done_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_ack_i    (mem_ack_i),
    .mem_addr_o   (mem_addr_o)
);

`default_nettype wire

// File: verification/dcache_tb.sv
// Testbench for the data cache with victim buffer
// Random loads, stores and flushes, memory responder with random latency,
// reference model of memory image, tag state and victim FIFO, final report
`default_nettype none

module dcache_tb;

    localparam int SEED          = 11906;
    localparam int CLK_PERIOD    = 8;
    localparam int NUM_OPS       = 600;
    localparam int REQ_TIMEOUT   = 300;
    localparam int FLUSH_TIMEOUT = 3000;
    localparam int LAT_MIN       = 1;
    localparam int LAT_MAX       = 6;

    logic                clk;
    logic                rst_n;
    logic                req_i;
    logic                we_i;
    logic [31:0]         addr_i;
    logic [31:0]         wdata_i;
    logic [3:0]          sel_byte_i;
    logic                flush_i;
    logic [31:0]         rdata_o;
    logic                ack_o;
    logic                flush_done_o;
    logic                mem_req_o;
    logic                mem_we_o;
    logic [31:0]         mem_addr_o;
    dcache_pkg::line_t   mem_wdata_o;
    dcache_pkg::line_t   mem_rdata_i;
    logic                mem_ack_i;

    dcache_pkg::line_t   mem_lines [bit [27:0]];  // Memory responder contents
    dcache_pkg::line_t   img [bit [27:0]];        // Expected contents seen by loads
    bit                  m_valid [64];
    bit                  m_dirty [64];
    bit [21:0]           m_tag [64];
    bit                  v_valid [4];
    bit [27:0]           v_addr [4];
    int                  v_ptr;
    bit                  ev_we [$];               // Memory requests since last clear
    bit [31:0]           ev_addr [$];
    dcache_pkg::line_t   ev_data [$];
    int                  errors;
    int                  timeouts;

    dcache_top i_dut (
        .clk (clk), .rst_n (rst_n), .req_i (req_i), .we_i (we_i), .addr_i (addr_i),
        .wdata_i (wdata_i), .sel_byte_i (sel_byte_i), .flush_i (flush_i),
        .rdata_o (rdata_o), .ack_o (ack_o), .flush_done_o (flush_done_o),
        .mem_req_o (mem_req_o), .mem_we_o (mem_we_o), .mem_addr_o (mem_addr_o),
        .mem_wdata_o (mem_wdata_o), .mem_rdata_i (mem_rdata_i), .mem_ack_i (mem_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Untouched memory holds a pattern of the full byte address
    function automatic dcache_pkg::line_t fill_line(bit [27:0] la);
        dcache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = ({la, 4'(w * 4)} * 32'h9e37_79b9) ^ 32'h5a3c_0f96;
        end
        return l;
    endfunction

    function automatic dcache_pkg::line_t stored_line(bit [27:0] la);
        if (mem_lines.exists(la)) return mem_lines[la];
        return fill_line(la);
    endfunction

    function automatic dcache_pkg::line_t expected_line(bit [27:0] la);
        if (img.exists(la)) return img[la];
        return fill_line(la);
    endfunction

    // Few tags times few sets so that conflicts and victim reuse are frequent
    function automatic bit [31:0] rand_addr();
        bit [21:0] tags [4] = '{22'h00_0001, 22'h00_0a5c, 22'h2a_5a5a, 22'h3f_ffff};
        bit [5:0]  sets [3] = '{6'd0, 6'd17, 6'd63};
        return {tags[$urandom_range(3, 0)], sets[$urandom_range(2, 0)],
                2'($urandom_range(3, 0)), 2'b00};
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_log();
        ev_we.delete();
        ev_addr.delete();
        ev_data.delete();
    endtask

    // Ring of four slots where a new line overwrites the oldest slot
    task automatic push_victim(input bit [27:0] la);
        v_valid[v_ptr] = 1'b1;
        v_addr[v_ptr]  = la;
        v_ptr          = (v_ptr + 1) % 4;
    endtask

    function automatic bit take_victim(bit [27:0] la);
        for (int i = 0; i < 4; i++) begin
            if (v_valid[i] && v_addr[i] == la) begin
                v_valid[i] = 1'b0;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Counts edges after the driving edge until ack_o is seen
    task automatic wait_ack(output int edges, output bit got);
        edges = 0;
        got   = 1'b0;
        while (!got && edges < REQ_TIMEOUT) begin
            @(negedge clk);
            got = ack_o;
            if (!got) edges++;
        end
        if (!got) begin
            $display("Timeout: no ack_o for address 0x%h", addr_i);
            timeouts++;
        end
    endtask

    task automatic wait_flush_done(output bit got);
        int cycles;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < FLUSH_TIMEOUT) begin
            @(negedge clk);
            got = flush_done_o;
            cycles++;
        end
        if (!got) begin
            $display("Timeout: flush did not complete");
            timeouts++;
        end
    endtask

    task automatic access(input bit we, input bit [31:0] addr, input bit [31:0] wdata,
                          input bit [3:0] sel);
        bit [27:0]          la;
        bit [5:0]           idx;
        bit [27:0]          old_la;
        bit                 hit;
        bit                 wb;
        bit                 from_victim;
        bit                 got;
        int                 edges;
        int                 exp_n;
        int                 k;
        dcache_pkg::line_t  line;
        la          = addr[31:4];
        idx         = addr[9:4];
        old_la      = {m_tag[idx], idx};
        hit         = m_valid[idx] && (m_tag[idx] == addr[31:10]);
        wb          = !hit && m_valid[idx] && m_dirty[idx];
        from_victim = 1'b0;
        clear_log();
        @(posedge clk);
        req_i      <= 1'b1;
        we_i       <= we;
        addr_i     <= addr;
        wdata_i    <= wdata;
        sel_byte_i <= sel;
        wait_ack(edges, got);
        if (got) begin
            if (hit) begin
                check("ack_o latency", edges, 2);
            end else begin
                if (m_valid[idx]) push_victim(old_la);  // Evicted line kept clean
                from_victim  = take_victim(la);
                m_valid[idx] = 1'b1;
                m_dirty[idx] = 1'b0;
                m_tag[idx]   = addr[31:10];
            end
            exp_n = hit ? 0 : int'(wb) + int'(!from_victim);
            check("memory request count", ev_we.size(), exp_n);
            if (ev_we.size() == exp_n) begin
                k = 0;
                if (wb) begin
                    check("mem_we_o", ev_we[0], 1'b1);
                    check("mem_addr_o", ev_addr[0], {old_la, 4'h0});
                    check("mem_wdata_o", ev_data[0], expected_line(old_la));
                    k = 1;
                end
                if (k < exp_n) begin
                    check("mem_we_o", ev_we[k], 1'b0);  // Refill read
                    check("mem_addr_o", ev_addr[k], {la, 4'h0});
                end
            end
            line = expected_line(la);
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) line[addr[3:2]*32 + b*8 +: 8] = wdata[b*8 +: 8];
                end
                img[la]      = line;
                m_dirty[idx] = 1'b1;
            end else begin
                check("rdata_o", rdata_o, line[addr[3:2]*32 +: 32]);
            end
        end
        @(posedge clk);
        req_i <= 1'b0;
    endtask

    task automatic flush_all();
        bit        got;
        int        exp_n;
        bit [5:0]  idx;
        bit [5:0]  dirty_sets [$];
        for (int s = 0; s < 64; s++) begin
            if (m_valid[s] && m_dirty[s]) dirty_sets.push_back(6'(s));
        end
        exp_n = dirty_sets.size();
        clear_log();
        @(posedge clk);
        flush_i <= 1'b1;
        wait_flush_done(got);
        if (got) begin
            check("flush writeback count", ev_we.size(), exp_n);
            if (ev_we.size() == exp_n) begin
                foreach (ev_we[k]) begin
                    idx = dirty_sets[k];  // Sets are walked in ascending order
                    check("mem_we_o", ev_we[k], 1'b1);
                    check("mem_addr_o", ev_addr[k], {m_tag[idx], idx, 4'h0});
                    check("mem_wdata_o", ev_data[k], expected_line({m_tag[idx], idx}));
                end
            end
            for (int s = 0; s < 64; s++) m_dirty[s] = 1'b0;
            for (int i = 0; i < 4; i++) v_valid[i] = 1'b0;
            v_ptr = 0;
            foreach (img[la]) check("memory line", stored_line(la), img[la]);
        end
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    // Line-wide memory that acks after a random delay
    initial begin : mem_responder
        int         lat;
        bit [27:0]  la;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_o) begin
                lat = $urandom_range(LAT_MAX, LAT_MIN);
                la  = mem_addr_o[31:4];
                ev_we.push_back(mem_we_o);
                ev_addr.push_back(mem_addr_o);
                ev_data.push_back(mem_wdata_o);
                repeat (lat) @(posedge clk);
                if (mem_we_o) mem_lines[la] = mem_wdata_o;
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= stored_line(la);
                @(posedge clk);
                mem_ack_i   <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        int op;
        void'($urandom(SEED));
        rst_n       <= 1'b0;
        req_i       <= 1'b0;
        we_i        <= 1'b0;
        addr_i      <= '0;
        wdata_i     <= '0;
        sel_byte_i  <= '0;
        flush_i     <= 1'b0;
        mem_ack_i   <= 1'b0;
        mem_rdata_i <= '0;
        errors      = 0;
        timeouts    = 0;
        v_ptr       = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_OPS && timeouts == 0; n++) begin
            op = $urandom_range(99, 0);
            if (op < 4) begin
                flush_all();
            end else begin
                access(op < 50, rand_addr(), $urandom(), 4'($urandom_range(15, 1)));
            end
        end
        $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, i_dut.i_props.fail_count);
        if (errors == 0 && timeouts == 0 && i_dut.i_props.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_top.f
rtl/dcache_pkg.sv
rtl/dcache_ctrl_if.sv
rtl/dcache_sram.sv
rtl/dcache_victim.sv
rtl/dcache_datapath.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/dcache_props.sv
verification/dcache_tb.sv
